// File: common/ddr3_pkg.sv
`default_nettype none

package ddr3_pkg;

  // ddr3 command encoding, {ras_n, cas_n, we_n}
  typedef enum logic [2:0] {
    CMD_MODE = 3'b000,
    CMD_REFR = 3'b001,
    CMD_PREC = 3'b010,
    CMD_ACTV = 3'b011,
    CMD_WRIT = 3'b100,
    CMD_READ = 3'b101,
    CMD_ZQCL = 3'b110,
    // deselect / nop, all strobes high
    CMD_NOOP = 3'b111
  } ddr3_cmd_e;

  // fast-path read sequencer states
  typedef enum logic [1:0] {
    ST_IDLE = 2'b00,
    ST_PREC = 2'b01,
    ST_ACTV = 2'b10,
    ST_READ = 2'b11
  } fp_state_e;

  // axi response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // axi incrementing burst
  localparam logic [1:0] BURST_INCR = 2'b01;

  // eight banks per device
  localparam int BANK_BITS = 3;

  // a10 selects all banks on precharge
  localparam int AP_BIT = 10;

endpackage

`default_nettype wire

// File: ddr3_fastpath/ddr3_open_rows.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_open_rows #(
  parameter int ROW_BITS = 13
) (
  input  wire                             clock,
  input  wire                             reset,
  // ddl accept strobe and the accepted command
  input  wire                             cmd_fire_i,
  input  wire ddr3_pkg::ddr3_cmd_e        cmd_i,
  input  wire [ddr3_pkg::BANK_BITS-1:0]   ba_i,
  input  wire [ROW_BITS-1:0]              adr_i,
  // lookup
  input  wire [ddr3_pkg::BANK_BITS-1:0]   query_ba_i,
  input  wire [ROW_BITS-1:0]              query_row_i,
  output logic                            open_o,
  output logic                            hit_o
);

  localparam int BANKS = 2 ** ddr3_pkg::BANK_BITS;

  // row held open in each bank
  logic [ROW_BITS-1:0] row_mem [BANKS];
  // one bit per bank, set while a row is active
  logic [BANKS-1:0]    open_q;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      open_q <= '0;
    end else if (cmd_fire_i) begin
      case (cmd_i)
        ddr3_pkg::CMD_ACTV: open_q[ba_i] <= 1'b1;
        ddr3_pkg::CMD_PREC: begin
          // precharge-all when a10 is set
          if (adr_i[ddr3_pkg::AP_BIT]) begin
            open_q <= '0;
          end else begin
            open_q[ba_i] <= 1'b0;
          end
        end
        // refresh needs every bank idle anyway
        ddr3_pkg::CMD_REFR: open_q <= '0;
        default: open_q <= open_q;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (cmd_fire_i && (cmd_i == ddr3_pkg::CMD_ACTV)) begin
      row_mem[ba_i] <= adr_i;
    end
  end

  assign open_o = open_q[query_ba_i];
  assign hit_o  = open_o && (row_mem[query_ba_i] == query_row_i);

endmodule

`default_nettype wire

// File: ddr3_fastpath/ddr3_fastpath.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_fastpath #(
  parameter int WIDTH    = 32,
  parameter int REQID    = 4,
  parameter int ROW_BITS = 13,
  parameter int COL_BITS = 10,
  parameter int ADDRS    = ROW_BITS + ddr3_pkg::BANK_BITS + COL_BITS
) (
  input  wire                              clock,
  input  wire                              reset,

  // axi read address channel
  input  wire                              axi_arvalid_i,
  output logic                             axi_arready_o,
  input  wire [ADDRS-1:0]                  axi_araddr_i,
  input  wire [REQID-1:0]                  axi_arid_i,
  input  wire [7:0]                        axi_arlen_i,
  input  wire [1:0]                        axi_arburst_i,

  // axi read data channel
  input  wire                              axi_rready_i,
  output logic                             axi_rvalid_o,
  output logic [WIDTH-1:0]                 axi_rdata_o,
  output logic [1:0]                       axi_rresp_o,
  output logic [REQID-1:0]                 axi_rid_o,
  output logic                             axi_rlast_o,

  // ddl command port
  input  wire                              ddl_run_i,
  output logic                             ddl_req_o,
  input  wire                              ddl_rdy_i,
  output ddr3_pkg::ddr3_cmd_e              ddl_cmd_o,
  output logic [ddr3_pkg::BANK_BITS-1:0]   ddl_ba_o,
  output logic [ROW_BITS-1:0]              ddl_adr_o,

  // ddl read data
  input  wire                              ddl_rvalid_i,
  output logic                             ddl_rready_o,
  input  wire                              ddl_rlast_i,
  input  wire [WIDTH-1:0]                  ddl_rdata_i,

  // controller-side commands, intercepted here
  input  wire                              ctl_req_i,
  output logic                             ctl_rdy_o,
  input  wire ddr3_pkg::ddr3_cmd_e         ctl_cmd_i,
  input  wire [ddr3_pkg::BANK_BITS-1:0]    ctl_ba_i,
  input  wire [ROW_BITS-1:0]               ctl_adr_i,
  // refresh in progress, holds off new reads
  input  wire                              ctl_busy_i,

  // open-row table lookup
  output logic [ddr3_pkg::BANK_BITS-1:0]   row_ba_o,
  output logic [ROW_BITS-1:0]              row_adr_o,
  input  wire                              row_open_i,
  input  wire                              row_hit_i
);

  ddr3_pkg::fp_state_e state_q;

  logic arready_q;
  // fast path has a command outstanding on the ddl
  logic fp_req_q;
  // unsupported request, single slverr beat pending
  logic err_q;

  // latched request
  logic [REQID-1:0]               id_q;
  logic [ddr3_pkg::BANK_BITS-1:0] ba_q;
  logic [ROW_BITS-1:0]            row_q;
  logic [COL_BITS-1:0]            col_q;

  logic ar_fire;
  logic ar_ok;
  logic r_fire;
  logic fp_fire;
  logic ctl_pass;
  logic rd_own;

  // address split, {row, bank, col}
  logic [ROW_BITS-1:0]            ar_row;
  logic [ddr3_pkg::BANK_BITS-1:0] ar_ba;
  logic [COL_BITS-1:0]            ar_col;

  assign ar_row = axi_araddr_i[ADDRS-1 -: ROW_BITS];
  assign ar_ba  = axi_araddr_i[COL_BITS +: ddr3_pkg::BANK_BITS];
  assign ar_col = axi_araddr_i[COL_BITS-1:0];

  // table lookup runs on the live request so the choice is made at accept
  assign row_ba_o  = ar_ba;
  assign row_adr_o = ar_row;

  assign axi_arready_o = arready_q;
  assign ar_fire = axi_arvalid_i && arready_q;
  // only single bl8, 4 x 32b incr bursts are served
  assign ar_ok   = (axi_arlen_i == 8'd3) && (axi_arburst_i == ddr3_pkg::BURST_INCR);
  assign fp_fire = fp_req_q && ddl_rdy_i;
  assign r_fire  = axi_rvalid_o && axi_rready_i;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q   <= ddr3_pkg::ST_IDLE;
      arready_q <= 1'b0;
      fp_req_q  <= 1'b0;
      err_q     <= 1'b0;
    end else if (!ddl_run_i) begin
      // ddl not running yet, stay parked
      state_q   <= ddr3_pkg::ST_IDLE;
      arready_q <= 1'b0;
      fp_req_q  <= 1'b0;
      err_q     <= 1'b0;
    end else begin
      // registered, so it drops the cycle after an accept
      arready_q <= axi_rready_i && !ctl_busy_i && !ar_fire &&
                   (state_q == ddr3_pkg::ST_IDLE);
      case (state_q)
        ddr3_pkg::ST_IDLE: begin
          if (ar_fire && !ar_ok) begin
            // no ddl traffic, just the error beat
            err_q   <= 1'b1;
            state_q <= ddr3_pkg::ST_READ;
          end else if (ar_fire) begin
            fp_req_q <= 1'b1;
            if (row_hit_i) begin
              state_q <= ddr3_pkg::ST_READ;
            end else if (row_open_i) begin
              // wrong row open, close it first
              state_q <= ddr3_pkg::ST_PREC;
            end else begin
              state_q <= ddr3_pkg::ST_ACTV;
            end
          end
        end
        ddr3_pkg::ST_PREC: begin
          if (fp_fire) begin
            state_q <= ddr3_pkg::ST_ACTV;
          end
        end
        ddr3_pkg::ST_ACTV: begin
          if (fp_fire) begin
            state_q <= ddr3_pkg::ST_READ;
          end
        end
        ddr3_pkg::ST_READ: begin
          // read issued, then wait for the burst to drain
          if (fp_fire) begin
            fp_req_q <= 1'b0;
          end
          if (r_fire && axi_rlast_o) begin
            state_q <= ddr3_pkg::ST_IDLE;
            err_q   <= 1'b0;
          end
        end
        default: begin
          state_q <= ddr3_pkg::ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      id_q  <= axi_arid_i;
      ba_q  <= ar_ba;
      row_q <= ar_row;
      col_q <= ar_col;
    end
  end

  // controller commands pass only while idle and not offering arready
  assign ctl_pass  = (state_q == ddr3_pkg::ST_IDLE) && !arready_q;
  assign ddl_req_o = fp_req_q || (ctl_pass && ctl_req_i);
  assign ctl_rdy_o = ctl_pass && ddl_rdy_i;

  // command intercept mux
  always_comb begin
    ddl_ba_o = ba_q;
    case (state_q)
      ddr3_pkg::ST_PREC: begin
        // single-bank precharge, a10 low
        ddl_cmd_o = ddr3_pkg::CMD_PREC;
        ddl_adr_o = '0;
      end
      ddr3_pkg::ST_ACTV: begin
        ddl_cmd_o = ddr3_pkg::CMD_ACTV;
        ddl_adr_o = row_q;
      end
      ddr3_pkg::ST_READ: begin
        ddl_cmd_o = fp_req_q ? ddr3_pkg::CMD_READ : ddr3_pkg::CMD_NOOP;
        ddl_adr_o = {{(ROW_BITS - COL_BITS){1'b0}}, col_q};
      end
      default: begin
        ddl_cmd_o = ctl_cmd_i;
        ddl_ba_o  = ctl_ba_i;
        ddl_adr_o = ctl_adr_i;
      end
    endcase
  end

  // read data belongs to the fast path for the whole of st_read
  assign rd_own = (state_q == ddr3_pkg::ST_READ) && !err_q;

  assign axi_rvalid_o = err_q || (rd_own && ddl_rvalid_i);
  assign axi_rlast_o  = err_q || (rd_own && ddl_rlast_i);
  assign axi_rdata_o  = ddl_rdata_i;
  assign axi_rresp_o  = err_q ? ddr3_pkg::RESP_SLVERR : ddr3_pkg::RESP_OKAY;
  assign axi_rid_o    = id_q;
  // r back-pressure stalls the ddl stream directly
  assign ddl_rready_o = axi_rready_i;

endmodule

`default_nettype wire

// File: logic/ddr3_refresh_sched.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_refresh_sched #(
  parameter int REFRESH_CYCLES = 400,
  parameter int ROW_BITS       = 13
) (
  input  wire                             clock,
  input  wire                             reset,
  input  wire                             run_i,
  // controller-side command port
  output logic                            req_o,
  input  wire                             rdy_i,
  output ddr3_pkg::ddr3_cmd_e             cmd_o,
  output logic [ddr3_pkg::BANK_BITS-1:0]  ba_o,
  output logic [ROW_BITS-1:0]             adr_o,
  // pending or mid-sequence
  output logic                            busy_o
);

  localparam int CNT_BITS = $clog2(REFRESH_CYCLES);

  logic [CNT_BITS-1:0] cnt_q;
  logic                tick;
  logic                pend_q;
  // precharge-all done, refresh next
  logic                refr_q;
  logic                fire;

  assign tick = run_i && (cnt_q == CNT_BITS'(REFRESH_CYCLES - 1));
  assign fire = req_o && rdy_i;

  // interval counter, frozen while the ddl is not running
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cnt_q <= '0;
    end else if (tick) begin
      cnt_q <= '0;
    end else if (run_i) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pend_q <= 1'b0;
      refr_q <= 1'b0;
    end else if (!run_i) begin
      pend_q <= 1'b0;
      refr_q <= 1'b0;
    end else begin
      if (fire) begin
        // two accepts, prec-all then refr
        refr_q <= !refr_q;
      end
      if (tick) begin
        pend_q <= 1'b1;
      end else if (fire && refr_q) begin
        pend_q <= 1'b0;
      end
    end
  end

  assign req_o  = pend_q && run_i;
  assign busy_o = pend_q;
  assign cmd_o  = refr_q ? ddr3_pkg::CMD_REFR : ddr3_pkg::CMD_PREC;
  assign ba_o   = '0;

  always_comb begin
    adr_o = '0;
    // a10 high selects all banks for the precharge
    adr_o[ddr3_pkg::AP_BIT] = !refr_q;
  end

endmodule

`default_nettype wire

// File: logic/ddr3_fastread_top.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_fastread_top #(
  parameter int WIDTH          = 32,
  parameter int REQID          = 4,
  parameter int ROW_BITS       = 13,
  parameter int COL_BITS       = 10,
  parameter int ADDRS          = ROW_BITS + ddr3_pkg::BANK_BITS + COL_BITS,
  parameter int REFRESH_CYCLES = 400
) (
  input  wire                             clock,
  input  wire                             reset,

  // axi read address channel
  input  wire                             axi_arvalid_i,
  output logic                            axi_arready_o,
  input  wire [ADDRS-1:0]                 axi_araddr_i,
  input  wire [REQID-1:0]                 axi_arid_i,
  input  wire [7:0]                       axi_arlen_i,
  input  wire [1:0]                       axi_arburst_i,

  // axi read data channel
  input  wire                             axi_rready_i,
  output logic                            axi_rvalid_o,
  output logic [WIDTH-1:0]                axi_rdata_o,
  output logic [1:0]                      axi_rresp_o,
  output logic [REQID-1:0]                axi_rid_o,
  output logic                            axi_rlast_o,

  // ddl command port
  input  wire                             ddl_run_i,
  output logic                            ddl_req_o,
  input  wire                             ddl_rdy_i,
  output ddr3_pkg::ddr3_cmd_e             ddl_cmd_o,
  output logic [ddr3_pkg::BANK_BITS-1:0]  ddl_ba_o,
  output logic [ROW_BITS-1:0]             ddl_adr_o,

  // ddl read data
  input  wire                             ddl_rvalid_i,
  output logic                            ddl_rready_o,
  input  wire                             ddl_rlast_i,
  input  wire [WIDTH-1:0]                 ddl_rdata_i
);

  // refresh scheduler to intercept mux
  logic                           ctl_req;
  logic                           ctl_rdy;
  ddr3_pkg::ddr3_cmd_e            ctl_cmd;
  logic [ddr3_pkg::BANK_BITS-1:0] ctl_ba;
  logic [ROW_BITS-1:0]            ctl_adr;
  logic                           ctl_busy;

  // open-row lookup
  logic [ddr3_pkg::BANK_BITS-1:0] row_ba;
  logic [ROW_BITS-1:0]            row_adr;
  logic                           row_open;
  logic                           row_hit;

  // table tracks exactly what the ddl took
  logic ddl_fire;
  assign ddl_fire = ddl_req_o && ddl_rdy_i;

  ddr3_fastpath #(
    .WIDTH    (WIDTH),
    .REQID    (REQID),
    .ROW_BITS (ROW_BITS),
    .COL_BITS (COL_BITS),
    .ADDRS    (ADDRS)
  ) u_fastpath (
    .clock         (clock),
    .reset         (reset),
    .axi_arvalid_i (axi_arvalid_i),
    .axi_arready_o (axi_arready_o),
    .axi_araddr_i  (axi_araddr_i),
    .axi_arid_i    (axi_arid_i),
    .axi_arlen_i   (axi_arlen_i),
    .axi_arburst_i (axi_arburst_i),
    .axi_rready_i  (axi_rready_i),
    .axi_rvalid_o  (axi_rvalid_o),
    .axi_rdata_o   (axi_rdata_o),
    .axi_rresp_o   (axi_rresp_o),
    .axi_rid_o     (axi_rid_o),
    .axi_rlast_o   (axi_rlast_o),
    .ddl_run_i     (ddl_run_i),
    .ddl_req_o     (ddl_req_o),
    .ddl_rdy_i     (ddl_rdy_i),
    .ddl_cmd_o     (ddl_cmd_o),
    .ddl_ba_o      (ddl_ba_o),
    .ddl_adr_o     (ddl_adr_o),
    .ddl_rvalid_i  (ddl_rvalid_i),
    .ddl_rready_o  (ddl_rready_o),
    .ddl_rlast_i   (ddl_rlast_i),
    .ddl_rdata_i   (ddl_rdata_i),
    .ctl_req_i     (ctl_req),
    .ctl_rdy_o     (ctl_rdy),
    .ctl_cmd_i     (ctl_cmd),
    .ctl_ba_i      (ctl_ba),
    .ctl_adr_i     (ctl_adr),
    .ctl_busy_i    (ctl_busy),
    .row_ba_o      (row_ba),
    .row_adr_o     (row_adr),
    .row_open_i    (row_open),
    .row_hit_i     (row_hit)
  );

  ddr3_open_rows #(
    .ROW_BITS (ROW_BITS)
  ) u_open_rows (
    .clock       (clock),
    .reset       (reset),
    .cmd_fire_i  (ddl_fire),
    .cmd_i       (ddl_cmd_o),
    .ba_i        (ddl_ba_o),
    .adr_i       (ddl_adr_o),
    .query_ba_i  (row_ba),
    .query_row_i (row_adr),
    .open_o      (row_open),
    .hit_o       (row_hit)
  );

  ddr3_refresh_sched #(
    .REFRESH_CYCLES (REFRESH_CYCLES),
    .ROW_BITS       (ROW_BITS)
  ) u_refresh_sched (
    .clock  (clock),
    .reset  (reset),
    .run_i  (ddl_run_i),
    .req_o  (ctl_req),
    .rdy_i  (ctl_rdy),
    .cmd_o  (ctl_cmd),
    .ba_o   (ctl_ba),
    .adr_o  (ctl_adr),
    .busy_o (ctl_busy)
  );

endmodule

`default_nettype wire

// File: verif/ddl_model.sv
`timescale 1ns/1ps
`default_nettype none

module ddl_model #(
  parameter int WIDTH    = 32,
  parameter int ROW_BITS = 13,
  parameter int COL_BITS = 10
) (
  input  wire                            clock,
  input  wire                            reset,
  // command port
  input  wire                            req_i,
  output logic                           rdy_o,
  input  wire [2:0]                      cmd_i,
  input  wire [ddr3_pkg::BANK_BITS-1:0]  ba_i,
  input  wire [ROW_BITS-1:0]             adr_i,
  // read data port
  output logic                           rvalid_o,
  input  wire                            rready_i,
  output logic                           rlast_o,
  output logic [WIDTH-1:0]               rdata_o,
  // 1 read to closed bank, 2 activate to open bank
  output logic [1:0]                     err_o
);

  logic [ROW_BITS-1:0]            row_mem [8];
  logic [7:0]                     open_q;
  logic [1:0]                     delay;
  logic [2:0]                     gap;
  logic [1:0]                     beat;
  logic [ddr3_pkg::BANK_BITS-1:0] rd_ba;
  logic [ROW_BITS-1:0]            rd_row;
  logic [COL_BITS-1:0]            rd_col;

  // sampled at the edge and applied 2 ns later
  logic                           s_fire;
  logic                           s_req;
  logic                           s_take;
  logic [2:0]                     s_cmd;
  logic [ddr3_pkg::BANK_BITS-1:0] s_ba;
  logic [ROW_BITS-1:0]            s_adr;

  // memory content built from every address bit plus the beat index
  function automatic logic [31:0] mem_word(input logic [2:0] ba, input logic [12:0] row,
                                           input logic [9:0] col, input logic [1:0] bt);
    return {4'h5, ba, row, col, bt};
  endfunction

  assign rlast_o = rvalid_o && (beat == 2'd3);
  assign rdata_o = mem_word(rd_ba, rd_row, rd_col, beat);

  always @(posedge clock) begin
    if (reset) begin
      rdy_o    = 1'b0;
      rvalid_o = 1'b0;
      open_q   = '0;
      delay    = 2'($urandom % 4);
      gap      = '0;
      beat     = '0;
      err_o    = '0;
    end else begin
      s_fire = req_i && rdy_o;
      s_req  = req_i;
      s_take = rvalid_o && rready_i;
      s_cmd  = cmd_i;
      s_ba   = ba_i;
      s_adr  = adr_i;
      #2;
      if (s_fire) begin
        case (s_cmd)
          ddr3_pkg::CMD_ACTV: begin
            if (open_q[s_ba]) err_o = 2'd2;
            open_q[s_ba]  = 1'b1;
            row_mem[s_ba] = s_adr;
          end
          ddr3_pkg::CMD_PREC: begin
            if (s_adr[ddr3_pkg::AP_BIT]) open_q = '0;
            else open_q[s_ba] = 1'b0;
          end
          ddr3_pkg::CMD_REFR: open_q = '0;
          ddr3_pkg::CMD_READ: begin
            if (!open_q[s_ba]) err_o = 2'd1;
            rd_ba  = s_ba;
            rd_row = row_mem[s_ba];
            rd_col = s_adr[COL_BITS-1:0];
            beat   = '0;
            // first beat shows up five cycles after the accept
            gap    = 3'd5;
          end
          default: ;
        endcase
        rdy_o = 1'b0;
        delay = 2'($urandom % 4);
      end else if (s_req && !rdy_o) begin
        if (delay == 0) rdy_o = 1'b1;
        else delay = delay - 1'b1;
      end
      if (s_take) begin
        if (beat == 2'd3) rvalid_o = 1'b0;
        else beat = beat + 1'b1;
      end
      if (gap != 0) begin
        gap = gap - 1'b1;
        if (gap == 0) rvalid_o = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: verif/ddr3_fastpath_properties.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_fastpath_properties #(
  parameter int ROW_BITS = 13
) (
  input  wire                            clock,
  input  wire                            reset,
  input  wire                            ddl_run_i,
  input  wire ddr3_pkg::fp_state_e       state_q,
  input  wire                            ddl_req_o,
  input  wire                            ddl_rdy_i,
  input  wire [2:0]                      ddl_cmd_o,
  input  wire [ddr3_pkg::BANK_BITS-1:0]  ddl_ba_o,
  input  wire [ROW_BITS-1:0]             ddl_adr_o,
  input  wire                            axi_arready_o,
  input  wire                            axi_rvalid_o
);

  // a command waiting for rdy keeps its fields
  req_held: assert property (@(posedge clock) disable iff (reset || !ddl_run_i)
    ddl_req_o && !ddl_rdy_i |=> ddl_req_o && $stable(ddl_cmd_o) &&
    $stable(ddl_ba_o) && $stable(ddl_adr_o))
    else $error("ddl_req dropped or changed before rdy");

  // new requests only taken while idle
  arready_idle: assert property (@(posedge clock) disable iff (reset)
    state_q != ddr3_pkg::ST_IDLE |-> !axi_arready_o)
    else $error("arready high outside ST_IDLE");

  rvalid_busy: assert property (@(posedge clock) disable iff (reset)
    state_q == ddr3_pkg::ST_IDLE |-> !axi_rvalid_o)
    else $error("rvalid high while ST_IDLE");

endmodule

bind ddr3_fastpath ddr3_fastpath_properties #(.ROW_BITS(ROW_BITS)) u_props (
  .clock         (clock),
  .reset         (reset),
  .ddl_run_i     (ddl_run_i),
  .state_q       (state_q),
  .ddl_req_o     (ddl_req_o),
  .ddl_rdy_i     (ddl_rdy_i),
  .ddl_cmd_o     (ddl_cmd_o),
  .ddl_ba_o      (ddl_ba_o),
  .ddl_adr_o     (ddl_adr_o),
  .axi_arready_o (axi_arready_o),
  .axi_rvalid_o  (axi_rvalid_o)
);

`default_nettype wire

// File: verif/ddr3_fastread_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ddr3_fastread_tb;

  localparam int WIDTH    = 32;
  localparam int REQID    = 4;
  localparam int ROW_BITS = 13;
  localparam int COL_BITS = 10;
  localparam int ADDRS    = ROW_BITS + ddr3_pkg::BANK_BITS + COL_BITS;
  localparam int N_RAND   = 40;
  // three directed reads, two unsupported, then the random run
  localparam int N_REQ    = 5 + N_RAND;
  localparam int LIMIT    = N_REQ * 200 + 4 + 10;

  logic                 clock;
  logic                 reset;
  logic                 arvalid;
  logic                 arready;
  logic [ADDRS-1:0]     araddr;
  logic [REQID-1:0]     arid;
  logic [7:0]           arlen;
  logic [1:0]           arburst;
  logic                 rready;
  logic                 rvalid;
  logic [WIDTH-1:0]     rdata;
  logic [1:0]           rresp;
  logic [REQID-1:0]     rid;
  logic                 rlast;
  logic                 ddl_run;
  logic                 ddl_req;
  logic                 ddl_rdy;
  ddr3_pkg::ddr3_cmd_e  ddl_cmd;
  logic [2:0]           ddl_ba;
  logic [ROW_BITS-1:0]  ddl_adr;
  logic                 ddl_rvalid;
  logic                 ddl_rready;
  logic                 ddl_rlast;
  logic [WIDTH-1:0]     ddl_rdata;
  logic [1:0]           model_err;

  // reference open-row table and expected traffic
  logic [7:0]           ref_open;
  logic [ROW_BITS-1:0]  ref_row [8];
  logic [2:0]           exp_cmd [$];
  logic [2:0]           exp_ba [$];
  logic [ROW_BITS-1:0]  exp_adr [$];
  logic [WIDTH-1:0]     exp_data [$];
  logic [1:0]           exp_resp [$];
  logic                 exp_last [$];
  logic [REQID-1:0]     exp_id;

  logic                 in_flight;
  logic                 busy_prev;
  logic                 bp_en;
  int                   ar_count;
  int                   done_count;
  int                   refresh_count;

  // scratch for the compare process
  logic [2:0]           c_cmd;
  logic [2:0]           c_ba;
  logic [ROW_BITS-1:0]  c_adr;
  logic [WIDTH-1:0]     c_data;
  logic [1:0]           c_resp;
  logic                 c_last;

  ddr3_fastread_top #(
    .REFRESH_CYCLES (400)
  ) dut_i (
    .clock         (clock),
    .reset         (reset),
    .axi_arvalid_i (arvalid),
    .axi_arready_o (arready),
    .axi_araddr_i  (araddr),
    .axi_arid_i    (arid),
    .axi_arlen_i   (arlen),
    .axi_arburst_i (arburst),
    .axi_rready_i  (rready),
    .axi_rvalid_o  (rvalid),
    .axi_rdata_o   (rdata),
    .axi_rresp_o   (rresp),
    .axi_rid_o     (rid),
    .axi_rlast_o   (rlast),
    .ddl_run_i     (ddl_run),
    .ddl_req_o     (ddl_req),
    .ddl_rdy_i     (ddl_rdy),
    .ddl_cmd_o     (ddl_cmd),
    .ddl_ba_o      (ddl_ba),
    .ddl_adr_o     (ddl_adr),
    .ddl_rvalid_i  (ddl_rvalid),
    .ddl_rready_o  (ddl_rready),
    .ddl_rlast_i   (ddl_rlast),
    .ddl_rdata_i   (ddl_rdata)
  );

  ddl_model #(
    .WIDTH    (WIDTH),
    .ROW_BITS (ROW_BITS),
    .COL_BITS (COL_BITS)
  ) u_ddl (
    .clock    (clock),
    .reset    (reset),
    .req_i    (ddl_req),
    .rdy_o    (ddl_rdy),
    .cmd_i    (ddl_cmd),
    .ba_i     (ddl_ba),
    .adr_i    (ddl_adr),
    .rvalid_o (ddl_rvalid),
    .rready_i (ddl_rready),
    .rlast_o  (ddl_rlast),
    .rdata_o  (ddl_rdata),
    .err_o    (model_err)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic stop_with_failure(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "simulation stopped on first error");
  endtask

  // expected word for one beat of a burst
  function automatic logic [31:0] beat_data(input logic [2:0] ba, input logic [12:0] row,
                                            input logic [9:0] col, input int bt);
    return {4'h5, ba, row, col, 2'(bt)};
  endfunction

  // open-row reference that queues the command list a read needs
  function automatic void expect_cmds(input logic [2:0] ba, input logic [ROW_BITS-1:0] row,
                                      input logic [COL_BITS-1:0] col);
    if (ref_open[ba] && ref_row[ba] != row) begin
      // single-bank precharge with a10 low
      exp_cmd.push_back(ddr3_pkg::CMD_PREC);
      exp_ba.push_back(ba);
      exp_adr.push_back('0);
    end
    if (!ref_open[ba] || ref_row[ba] != row) begin
      exp_cmd.push_back(ddr3_pkg::CMD_ACTV);
      exp_ba.push_back(ba);
      exp_adr.push_back(row);
    end
    exp_cmd.push_back(ddr3_pkg::CMD_READ);
    exp_ba.push_back(ba);
    exp_adr.push_back({{(ROW_BITS - COL_BITS){1'b0}}, col});
    ref_open[ba] = 1'b1;
    ref_row[ba]  = row;
  endfunction

  // compare process samples everything on the rising edge
  always @(posedge clock) begin
    if (!reset) begin
      assert (model_err != 2'd1)
        else stop_with_failure("DDL model got a READ to a closed bank");
      assert (model_err != 2'd2)
        else stop_with_failure("DDL model got an ACTV to an open bank");
      // r back-pressure reaches the ddl unchanged
      assert (ddl_rready == rready) else stop_with_failure(
        $sformatf("CHECK FAILED: ddl_rready exp %h got %h", rready, ddl_rready));
      // only one read at a time
      assert (!(arready && in_flight))
        else stop_with_failure("arready was high while a read was in flight");
      if (ddl_req && ddl_rdy) begin
        if (ddl_cmd == ddr3_pkg::CMD_REFR ||
            (ddl_cmd == ddr3_pkg::CMD_PREC && ddl_adr[ddr3_pkg::AP_BIT])) begin
          assert (!in_flight)
            else stop_with_failure("a refresh command reached the DDL during a read");
          ref_open = '0;
          if (ddl_cmd == ddr3_pkg::CMD_REFR) refresh_count++;
        end else begin
          assert (exp_cmd.size() != 0)
            else stop_with_failure("the DDL accepted a command nobody expected");
          c_cmd = exp_cmd.pop_front();
          c_ba  = exp_ba.pop_front();
          c_adr = exp_adr.pop_front();
          assert (ddl_cmd == c_cmd) else stop_with_failure(
            $sformatf("CHECK FAILED: ddl_cmd exp %h got %h", c_cmd, ddl_cmd));
          assert (ddl_ba == c_ba) else stop_with_failure(
            $sformatf("CHECK FAILED: ddl_ba exp %h got %h", c_ba, ddl_ba));
          assert (ddl_adr == c_adr) else stop_with_failure(
            $sformatf("CHECK FAILED: ddl_adr exp %h got %h", c_adr, ddl_adr));
        end
      end
      if (arvalid && arready) begin
        // busy seen a cycle earlier must already have blocked arready
        assert (!busy_prev)
          else stop_with_failure("a read was accepted while refresh was busy");
        exp_id = arid;
        if (arlen == 8'd3 && arburst == ddr3_pkg::BURST_INCR) begin
          expect_cmds(araddr[COL_BITS +: 3], araddr[ADDRS-1 -: ROW_BITS],
                      araddr[COL_BITS-1:0]);
          for (int i = 0; i < 4; i++) begin
            exp_data.push_back(beat_data(araddr[COL_BITS +: 3], araddr[ADDRS-1 -: ROW_BITS],
                                         araddr[COL_BITS-1:0], i));
            exp_resp.push_back(ddr3_pkg::RESP_OKAY);
            exp_last.push_back(i == 3);
          end
        end else begin
          exp_data.push_back('0);
          exp_resp.push_back(ddr3_pkg::RESP_SLVERR);
          exp_last.push_back(1'b1);
        end
        in_flight = 1'b1;
        ar_count++;
      end
      if (rvalid && rready) begin
        assert (exp_data.size() != 0)
          else stop_with_failure("an R beat arrived with no read outstanding");
        c_data = exp_data.pop_front();
        c_resp = exp_resp.pop_front();
        c_last = exp_last.pop_front();
        assert (rresp == c_resp) else stop_with_failure(
          $sformatf("CHECK FAILED: rresp exp %h got %h", c_resp, rresp));
        assert (rid == exp_id) else stop_with_failure(
          $sformatf("CHECK FAILED: rid exp %h got %h", exp_id, rid));
        assert (rlast == c_last) else stop_with_failure(
          $sformatf("CHECK FAILED: rlast exp %h got %h", c_last, rlast));
        if (c_resp == ddr3_pkg::RESP_OKAY) begin
          assert (rdata == c_data) else stop_with_failure(
            $sformatf("CHECK FAILED: rdata exp %h got %h", c_data, rdata));
        end
        if (c_last) begin
          in_flight = 1'b0;
          done_count++;
        end
      end
      busy_prev = dut_i.ctl_busy;
    end
  end

  // back-pressure on R when enabled
  always @(posedge clock) begin
    #2;
    rready = !bp_en || ($urandom % 4 != 0);
  end

  task automatic do_read(input logic [2:0] ba, input logic [ROW_BITS-1:0] row,
                         input logic [COL_BITS-1:0] col, input logic [REQID-1:0] id,
                         input logic [7:0] len, input logic [1:0] burst);
    int n;
    int d;
    n = ar_count;
    d = done_count;
    @(posedge clock);
    #2;
    arvalid = 1'b1;
    araddr  = {row, ba, col};
    arid    = id;
    arlen   = len;
    arburst = burst;
    wait (ar_count != n);
    #2;
    arvalid = 1'b0;
    wait (done_count == d + 1);
  endtask

  // watchdog
  initial begin
    repeat (LIMIT) @(posedge clock);
    stop_with_failure("watchdog timeout, the run did not finish in time");
  end

  initial begin
    void'($urandom(9479));
    reset = 1'b1;
    arvalid = 1'b0;
    araddr = '0;
    arid = '0;
    arlen = '0;
    arburst = '0;
    rready = 1'b1;
    ddl_run = 1'b0;
    bp_en = 1'b0;
    ref_open = '0;
    in_flight = 1'b0;
    busy_prev = 1'b0;
    ar_count = 0;
    done_count = 0;
    refresh_count = 0;
    repeat (4) @(posedge clock);
    #2;
    reset = 1'b0;
    ddl_run = 1'b1;

    // closed bank, row hit, row conflict
    do_read(3'd2, 13'd5, 10'h008, 4'd1, 8'd3, ddr3_pkg::BURST_INCR);
    do_read(3'd2, 13'd5, 10'h010, 4'd2, 8'd3, ddr3_pkg::BURST_INCR);
    do_read(3'd2, 13'd9, 10'h020, 4'd3, 8'd3, ddr3_pkg::BURST_INCR);
    // unsupported length and burst type
    do_read(3'd4, 13'd1, 10'h000, 4'd4, 8'd7, ddr3_pkg::BURST_INCR);
    do_read(3'd4, 13'd1, 10'h000, 4'd5, 8'd3, 2'b10);

    // long random run with R back-pressure across several refresh intervals
    bp_en = 1'b1;
    for (int i = 0; i < N_RAND; i++) begin
      do_read(3'($urandom % 8), 13'($urandom % 4), 10'($urandom % 1024),
              4'($urandom % 16), 8'd3, ddr3_pkg::BURST_INCR);
    end
    bp_en = 1'b0;

    // the random run has to cross at least one refresh
    if (refresh_count > 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      stop_with_failure("no refresh reached the DDL during the random run");
    end
  end

endmodule

`default_nettype wire

// File: ddr3_fastread_top.f
common/ddr3_pkg.sv
ddr3_fastpath/ddr3_open_rows.sv
ddr3_fastpath/ddr3_fastpath.sv
logic/ddr3_refresh_sched.sv
logic/ddr3_fastread_top.sv
verif/ddl_model.sv
verif/ddr3_fastpath_properties.sv
verif/ddr3_fastread_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module ddr3_fastread_tb \
  -f ddr3_fastread_top.f -o ddr3_fastread_sim

./obj_dir/ddr3_fastread_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "^TB PASSED$" sim.log; then
  exit 0
else
  exit 1
fi
